/* logic/ckv_cfg.svh */
// ==========================================================
// Sizes shared by every module of the checkpoint valid array
// The address must hold checkpoint bits above register bits
// Data width must be at least 4 for opcode and copy source
// ==========================================================
`ifndef CKV_CFG_SVH
`define CKV_CFG_SVH

// Number of branch checkpoints, one column each
`define CKV_NCHECK 4

// Number of physical registers, one bit per column each
`define CKV_PREGS 32

// Direct combinational read ports for the core
`define CKV_NRDPORT 4

// Wishbone widths, address is {checkpoint, register}
`define CKV_ADR_W 7
`define CKV_DAT_W 8

`endif

/* logic/ckv_index_pkg.sv */
// ==========================================================
// Index and vector types for checkpoints and registers
// Widths follow the counts in the config header
// ==========================================================
`default_nettype none

`include "ckv_cfg.svh"

package ckv_index_pkg;

	// Bit widths of the two index fields
	localparam int CKPT_W = $clog2(`CKV_NCHECK);
	localparam int PREG_W = $clog2(`CKV_PREGS);

	// Selects one checkpoint column
	typedef logic [CKPT_W-1:0] checkpt_ndx_t;

	// Physical register number
	typedef logic [PREG_W-1:0] pregno_t;

	// One column, bit n belongs to register n
	typedef logic [`CKV_PREGS-1:0] valid_vec_t;

endpackage

`default_nettype wire

/* logic/ckv_cmd_pkg.sv */
// ==========================================================
// Command opcodes carried in the Wishbone write data
// and the states of the bus slave FSM
// ==========================================================
`default_nettype none

package ckv_cmd_pkg;

	// Opcode sits in write data bits [1:0]
	typedef enum logic [1:0] {
		// Clear one bit in the target column
		OP_CLR_BIT = 2'd0,
		// Set one bit in the target column
		OP_SET_BIT = 2'd1,
		// Set the register valid in every column
		OP_SET_ALL = 2'd2,
		// Load the target column from the source column
		OP_COPY    = 2'd3
	} ckv_op_t;

	// Bus slave states
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_ACK  = 2'd1,
		ST_WAIT = 2'd2
	} bus_state_t;

endpackage

`default_nettype wire

/* logic/ckv_bus_decoder.sv */
// ==========================================================
// Wishbone classic slave, ack only, no bursts or errors
// Each cycle is accepted once and acked one edge later
// A write acts on the ack edge, read data is pre-write state
// ==========================================================
`default_nettype none

`include "ckv_cfg.svh"

module ckv_bus_decoder (
	input  wire                          clka,
	input  wire                          rst_n,
	input  wire                          wb_cyc,
	input  wire                          wb_stb,
	input  wire                          wb_we,
	input  wire [`CKV_ADR_W-1:0]         wb_adr,
	input  wire [`CKV_DAT_W-1:0]         wb_dat_w,
	output logic                         wb_ack,
	output logic [`CKV_DAT_W-1:0]        wb_dat_r,
	input  wire                          bus_bit,
	output logic [`CKV_NCHECK-1:0]       col_sel,
	output logic                         col_set,
	output logic                         col_clr,
	output logic                         col_all,
	output logic                         col_load,
	output ckv_index_pkg::pregno_t       col_preg,
	output ckv_index_pkg::checkpt_ndx_t  copy_src,
	output ckv_index_pkg::checkpt_ndx_t  bus_ckpt,
	output ckv_index_pkg::pregno_t       bus_preg
);

	import ckv_index_pkg::*;
	import ckv_cmd_pkg::*;

	bus_state_t state;
	ckv_op_t    op;
	logic       accept;
	logic       wr_acc;

	// ========================================================
	// Address and command fields
	// ========================================================

	// Upper address bits pick the checkpoint, lower the register
	assign bus_ckpt = wb_adr[`CKV_ADR_W-1:PREG_W];
	assign bus_preg = wb_adr[PREG_W-1:0];
	assign col_preg = bus_preg;

	// Opcode and copy source live in the low data bits
	assign op       = ckv_op_t'(wb_dat_w[1:0]);
	assign copy_src = wb_dat_w[2 +: CKPT_W];

	// A request is taken only from idle, so each cycle acts once
	assign accept = (state == ST_IDLE) && wb_cyc && wb_stb;
	assign wr_acc = accept && wb_we;

	// Controls are one cycle wide because the FSM leaves idle
	assign col_set  = wr_acc && (op == OP_SET_BIT);
	assign col_clr  = wr_acc && (op == OP_CLR_BIT);
	assign col_all  = wr_acc && (op == OP_SET_ALL);
	assign col_load = wr_acc && (op == OP_COPY);

	// One-hot column select, every column for a set-all
	always_comb begin
		for (int c = 0; c < `CKV_NCHECK; c++) begin
			col_sel[c] = wr_acc && (col_all || bus_ckpt == checkpt_ndx_t'(c));
		end
	end

	// ========================================================
	// Bus FSM
	// ========================================================
	always_ff @(posedge clka or negedge rst_n) begin
		if (!rst_n) begin
			state  <= ST_IDLE;
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= accept;
			case (state)
				ST_IDLE: begin
					if (accept)
						state <= ST_ACK;
				end
				ST_ACK: begin
					// Master still holding the strobe means we must wait it out
					if (wb_cyc && wb_stb)
						state <= ST_WAIT;
					else
						state <= ST_IDLE;
				end
				ST_WAIT: begin
					if (!(wb_cyc && wb_stb))
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Read data is sampled with ack, before the edge's write lands
	always_ff @(posedge clka) begin
		if (accept && !wb_we)
			wb_dat_r <= {{(`CKV_DAT_W-1){1'b0}}, bus_bit};
	end

endmodule

`default_nettype wire

/* logic/ckv_column.sv */
// ==========================================================
// Valid vector of one checkpoint, all ones after reset
// Only one operation acts per edge, load wins over clear
// and clear wins over set
// ==========================================================
`default_nettype none

`include "ckv_cfg.svh"

module ckv_column (
	input  wire                         clka,
	input  wire                         rst_n,
	input  wire                         sel,
	input  wire                         set_bit,
	input  wire                         clr_bit,
	input  wire                         load,
	input  ckv_index_pkg::pregno_t      preg,
	input  ckv_index_pkg::valid_vec_t   load_vec,
	output ckv_index_pkg::valid_vec_t   vec
);

	// Every register starts valid in every checkpoint
	always_ff @(posedge clka or negedge rst_n) begin
		if (!rst_n) begin
			vec <= {`CKV_PREGS{1'b1}};
		end else if (sel) begin
			if (load) begin
				// New checkpoint taken, copy the whole source column
				vec <= load_vec;
			end else if (clr_bit) begin
				// Register allocated, not yet valid in this checkpoint
				vec[preg] <= 1'b0;
			end else if (set_bit) begin
				// Written back, or set-all reaching every column
				vec[preg] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/ckv_read_select.sv */
// ==========================================================
// Combinational selector over all checkpoint columns
// Direct ports have zero latency and show post-edge state
// ==========================================================
`default_nettype none

`include "ckv_cfg.svh"

module ckv_read_select (
	input  ckv_index_pkg::valid_vec_t     vecs [`CKV_NCHECK],
	input  ckv_index_pkg::checkpt_ndx_t   rd_ckpt [`CKV_NRDPORT],
	input  ckv_index_pkg::pregno_t        rd_preg [`CKV_NRDPORT],
	output logic [`CKV_NRDPORT-1:0]       rd_valid,
	input  ckv_index_pkg::checkpt_ndx_t   bus_ckpt,
	input  ckv_index_pkg::pregno_t        bus_preg,
	output logic                          bus_bit,
	input  ckv_index_pkg::checkpt_ndx_t   copy_src,
	output ckv_index_pkg::valid_vec_t     copy_vec
);

	import ckv_index_pkg::*;

	valid_vec_t bus_vec;

	// ========================================================
	// Direct read ports for the core
	// ========================================================
	always_comb begin
		for (int p = 0; p < `CKV_NRDPORT; p++) begin
			rd_valid[p] = vecs[rd_ckpt[p]][rd_preg[p]];
		end
	end

	// ========================================================
	// Bus read and copy source
	// ========================================================

	// Column first, then the bit, as the bus address is laid out
	assign bus_vec = vecs[bus_ckpt];
	assign bus_bit = bus_vec[bus_preg];

	// Whole source column for OP_COPY, taken before the edge updates it
	assign copy_vec = vecs[copy_src];

endmodule

`default_nettype wire

/* logic/ckv_top.sv */
// ==========================================================
// Checkpoint valid array, single clock domain on clka
// One bus command per cycle, no rename map storage
// Direct read ports see the state after the last edge
// ==========================================================
`default_nettype none

`include "ckv_cfg.svh"

module ckv_top (
	input  wire                           clka,
	input  wire                           rst_n,
	input  wire                           wb_cyc,
	input  wire                           wb_stb,
	input  wire                           wb_we,
	input  wire [`CKV_ADR_W-1:0]          wb_adr,
	input  wire [`CKV_DAT_W-1:0]          wb_dat_w,
	output logic [`CKV_DAT_W-1:0]         wb_dat_r,
	output logic                          wb_ack,
	input  ckv_index_pkg::checkpt_ndx_t   rd_ckpt [`CKV_NRDPORT],
	input  ckv_index_pkg::pregno_t        rd_preg [`CKV_NRDPORT],
	output logic [`CKV_NRDPORT-1:0]       rd_valid
);

	import ckv_index_pkg::*;

	// Decoder to column controls
	logic [`CKV_NCHECK-1:0] col_sel;
	logic                   col_set;
	logic                   col_clr;
	logic                   col_all;
	logic                   col_load;
	pregno_t                col_preg;

	// Bus read and copy paths through the selector
	checkpt_ndx_t           copy_src;
	checkpt_ndx_t           bus_ckpt;
	pregno_t                bus_preg;
	logic                   bus_bit;
	valid_vec_t             copy_vec;
	valid_vec_t             vecs [`CKV_NCHECK];

	ckv_bus_decoder u_dec (
		.clka     (clka),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_ack   (wb_ack),
		.wb_dat_r (wb_dat_r),
		.bus_bit  (bus_bit),
		.col_sel  (col_sel),
		.col_set  (col_set),
		.col_clr  (col_clr),
		.col_all  (col_all),
		.col_load (col_load),
		.col_preg (col_preg),
		.copy_src (copy_src),
		.bus_ckpt (bus_ckpt),
		.bus_preg (bus_preg)
	);

	// One column per checkpoint, set-all arrives as a set with every select high
	for (genvar c = 0; c < `CKV_NCHECK; c++) begin : gcol
		ckv_column u_col (
			.clka     (clka),
			.rst_n    (rst_n),
			.sel      (col_sel[c]),
			.set_bit  (col_set | col_all),
			.clr_bit  (col_clr),
			.load     (col_load),
			.preg     (col_preg),
			.load_vec (copy_vec),
			.vec      (vecs[c])
		);
	end

	ckv_read_select u_rsel (
		.vecs     (vecs),
		.rd_ckpt  (rd_ckpt),
		.rd_preg  (rd_preg),
		.rd_valid (rd_valid),
		.bus_ckpt (bus_ckpt),
		.bus_preg (bus_preg),
		.bus_bit  (bus_bit),
		.copy_src (copy_src),
		.copy_vec (copy_vec)
	);

endmodule

`default_nettype wire

/* tb/ckv_chk.sv */
// ==========================================================
// Wishbone ack checks, bound into the top level
// Assumes a single clock and an active low reset
// ==========================================================
`default_nettype none

module ckv_chk (
	input wire clka,
	input wire rst_n,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_ack
);

	// Ack is a pulse of exactly one cycle
	ack_single: assert property (@(posedge clka) disable iff (!rst_n) wb_ack |=> !wb_ack)
		else $error("wb_ack high for two cycles in a row");

	// Every ack answers a strobe seen on the edge before
	ack_after_req: assert property (@(posedge clka) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack without cyc and stb on the previous edge");

	// Ack is held low for the whole reset
	ack_in_reset: assert property (@(posedge clka) !rst_n |-> !wb_ack)
		else $error("wb_ack high during reset");

endmodule

`default_nettype wire

/* tb/ckv_tb.sv */
// ==========================================================
// Testbench for the checkpoint valid array
// A bit model is updated on each write ack, and the direct
// ports are randomized every cycle and checked against it
// ==========================================================
`default_nettype none

`include "ckv_cfg.svh"

module ckv_tb;

	import ckv_index_pkg::*;
	import ckv_cmd_pkg::*;

	// Up to about 3100 cycles of bus traffic plus reset, with margin
	localparam int MAX_CYCLES = 4000;

	logic                    clka;
	logic                    rst_n;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	logic [`CKV_ADR_W-1:0]   wb_adr;
	logic [`CKV_DAT_W-1:0]   wb_dat_w;
	logic [`CKV_DAT_W-1:0]   wb_dat_r;
	logic                    wb_ack;
	checkpt_ndx_t            rd_ckpt [`CKV_NRDPORT];
	pregno_t                 rd_preg [`CKV_NRDPORT];
	logic [`CKV_NRDPORT-1:0] rd_valid;

	// Expected valid bit per checkpoint and register
	logic model [`CKV_NCHECK][`CKV_PREGS];
	int   seed;
	int   errors = 0;
	int   issued = 0;
	int   acks = 0;
	int   cycles = 0;

	// Extra cycles the master keeps the strobe up after it sees ack
	int   stb_hold = 0;

	ckv_top dut0 (.*);

	bind ckv_top ckv_chk chk0 (.clka(clka), .rst_n(rst_n), .wb_cyc(wb_cyc),
		.wb_stb(wb_stb), .wb_ack(wb_ack));

	initial begin
		clka = 1'b0;
		forever #4 clka = ~clka;
	end

	// ========================================================
	// Reference model
	// ========================================================
	function automatic logic ref_valid(input checkpt_ndx_t ckpt, input pregno_t preg);
		return model[ckpt][preg];
	endfunction

	function automatic void model_write(input logic [`CKV_ADR_W-1:0] adr,
			input logic [`CKV_DAT_W-1:0] dat);
		checkpt_ndx_t ck;
		pregno_t      pr;
		checkpt_ndx_t src;
		logic         col [`CKV_PREGS];
		ck  = adr[`CKV_ADR_W-1:PREG_W];
		pr  = adr[PREG_W-1:0];
		src = dat[2 +: CKPT_W];
		case (ckv_op_t'(dat[1:0]))
			OP_CLR_BIT: model[ck][pr] = 1'b0;
			OP_SET_BIT: model[ck][pr] = 1'b1;
			OP_SET_ALL: begin
				for (int c = 0; c < `CKV_NCHECK; c++)
					model[c][pr] = 1'b1;
			end
			OP_COPY: begin
				// Source is taken whole first, so a copy onto itself changes nothing
				for (int p = 0; p < `CKV_PREGS; p++)
					col[p] = model[src][p];
				for (int p = 0; p < `CKV_PREGS; p++)
					model[ck][p] = col[p];
			end
		endcase
	endfunction

	// ========================================================
	// Bus driver, all changes 1 unit after the rising edge
	// ========================================================
	task automatic bus_cycle(input logic we, input logic [`CKV_ADR_W-1:0] adr,
			input logic [`CKV_DAT_W-1:0] dat);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		issued++;
		do begin
			@(posedge clka);
			#1;
		end while (!wb_ack);
		// A strobe kept up past ack must not be taken as a second cycle
		repeat (stb_hold) begin
			@(posedge clka);
			#1;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		// Request fields stay put one more edge so the compare sees them with ack
		@(posedge clka);
		#1;
	endtask

	task automatic wb_write(input checkpt_ndx_t ck, input pregno_t pr, input ckv_op_t op,
			input checkpt_ndx_t src);
		bus_cycle(1'b1, {ck, pr}, {4'd0, src, op});
	endtask

	task automatic wb_read(input checkpt_ndx_t ck, input pregno_t pr);
		bus_cycle(1'b0, {ck, pr}, '0);
	endtask

	// Direct read ports get fresh random indices every cycle
	initial begin : port_drive
		logic [31:0] r;
		for (int p = 0; p < `CKV_NRDPORT; p++) begin
			rd_ckpt[p] = '0;
			rd_preg[p] = '0;
		end
		forever begin
			@(posedge clka);
			#1;
			for (int p = 0; p < `CKV_NRDPORT; p++) begin
				r = $random(seed);
				rd_ckpt[p] = r[CKPT_W-1:0];
				rd_preg[p] = r[8 +: PREG_W];
			end
		end
	end

	// ========================================================
	// Compare process, samples 2 units after the edge
	// ========================================================
	initial begin : compare
		logic                  ack_prev;
		logic [`CKV_DAT_W-1:0] exp_dat;
		ack_prev = 1'b0;
		forever begin
			@(posedge clka);
			#2;
			if (rst_n) begin
				if (wb_ack && ack_prev) begin
					errors++;
					$display("wb_ack stayed high for two cycles in a row");
				end
				if (wb_ack) begin
					acks++;
					exp_dat    = '0;
					exp_dat[0] = ref_valid(wb_adr[`CKV_ADR_W-1:PREG_W], wb_adr[PREG_W-1:0]);
					// Write lands on the ack edge, read data is the state before it
					if (wb_we) begin
						model_write(wb_adr, wb_dat_w);
					end else if (wb_dat_r !== exp_dat) begin
						errors++;
						$display("CHECK FAILED wb_dat_r adr %h: got %h exp %h",
							wb_adr, wb_dat_r, exp_dat);
					end
				end
				// Direct ports already show the state after this edge
				for (int p = 0; p < `CKV_NRDPORT; p++) begin
					if (rd_valid[p] !== ref_valid(rd_ckpt[p], rd_preg[p])) begin
						errors++;
						$display("CHECK FAILED rd_valid[%0d] ckpt %h preg %h: got %h exp %h",
							p, rd_ckpt[p], rd_preg[p], rd_valid[p],
							ref_valid(rd_ckpt[p], rd_preg[p]));
					end
				end
			end
			ack_prev = wb_ack;
		end
	end

	initial begin : watchdog
		while (cycles < MAX_CYCLES) begin
			@(posedge clka);
			cycles++;
		end
		$display("Timeout after %0d cycles with %0d errors", cycles, errors);
		$display("TB FAILED");
		$finish;
	end

	// ========================================================
	// Test sequence
	// ========================================================
	initial begin : main_seq
		logic [31:0]  r;
		checkpt_ndx_t ck;
		checkpt_ndx_t src;
		pregno_t      pr;
		seed     = 32'h7b50_866f;
		rst_n    = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		for (int c = 0; c < `CKV_NCHECK; c++)
			for (int p = 0; p < `CKV_PREGS; p++)
				model[c][p] = 1'b1;
		repeat (8) @(posedge clka);
		#1;
		rst_n = 1'b1;

		// Every bit reads as valid after reset
		for (int c = 0; c < `CKV_NCHECK; c++)
			for (int p = 0; p < `CKV_PREGS; p++)
				wb_read(checkpt_ndx_t'(c), pregno_t'(p));

		// Clear then set one bit, looking at another bit in between
		repeat (20) begin
			r  = $random(seed);
			ck = r[1:0];
			pr = r[6:2];
			wb_write(ck, pr, OP_CLR_BIT, '0);
			wb_read(ck, pr);
			wb_read(r[9:8], r[14:10]);
			wb_write(ck, pr, OP_SET_BIT, '0);
			wb_read(ck, pr);
		end

		// Set-all on one register while its neighbour stays cleared
		repeat (3) begin
			r  = $random(seed);
			pr = r[4:0];
			for (int c = 0; c < `CKV_NCHECK; c++) begin
				wb_write(checkpt_ndx_t'(c), pr, OP_CLR_BIT, '0);
				wb_write(checkpt_ndx_t'(c), pregno_t'(pr + 1), OP_CLR_BIT, '0);
			end
			wb_write(r[6:5], pr, OP_SET_ALL, '0);
			for (int c = 0; c < `CKV_NCHECK; c++) begin
				wb_read(checkpt_ndx_t'(c), pr);
				wb_read(checkpt_ndx_t'(c), pregno_t'(pr + 1));
			end
		end

		// Copy a dirtied column onto a different, also dirtied one
		r   = $random(seed);
		src = r[1:0];
		ck  = src + 2'd1;
		repeat (6) begin
			r = $random(seed);
			wb_write(src, r[4:0], OP_CLR_BIT, '0);
		end
		repeat (4) begin
			r = $random(seed);
			wb_write(ck, r[4:0], OP_CLR_BIT, '0);
		end
		wb_write(ck, r[9:5], OP_COPY, src);
		for (int p = 0; p < `CKV_PREGS; p++) begin
			wb_read(ck, pregno_t'(p));
			wb_read(src, pregno_t'(p));
		end

		// Random mix with idle gaps between bus cycles and strobes held past ack
		repeat (300) begin
			r = $random(seed);
			stb_hold = r[28:27];
			repeat (r[31:30]) begin
				@(posedge clka);
				#1;
			end
			if (r[29])
				wb_read(r[10:9], r[8:4]);
			else
				wb_write(r[10:9], r[8:4], ckv_op_t'(r[1:0]), r[3:2]);
		end

		repeat (2) @(posedge clka);
		#1;
		if (issued != acks)
			$display("Bus cycles issued %0d but acks seen %0d", issued, acks);
		$display("Errors %0d, bus cycles %0d, acks %0d, clock cycles %0d",
			errors, issued, acks, cycles);
		if (errors == 0 && issued == acks)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+logic
logic/ckv_index_pkg.sv
logic/ckv_cmd_pkg.sv
logic/ckv_bus_decoder.sv
logic/ckv_column.sv
logic/ckv_read_select.sv
logic/ckv_top.sv
tb/ckv_chk.sv
tb/ckv_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the checkpoint valid array testbench with Verilator and runs it
# The result is taken from the simulation log alone
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module ckv_tb > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vckv_tb > sim.log 2>&1 || echo "Simulation exited with an error status"
cat sim.log
grep -qx "TB PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
